// ==== cpu.f ====
+incdir+tb
hw/rv_pkg.sv
hw/mem_if.sv
hw/word_ram.sv
hw/fetch.sv
hw/reg_file.sv
hw/decode.sv
hw/execute.sv
hw/memory.sv
hw/cpu.sv
tb/tb_clock.sv
tb/cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cpu_tb -f cpu.f -o cpu_sim
./obj_dir/cpu_sim | tee sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
	echo "simulation failed"
	exit 1
fi
grep -q "Simulation finished: PASS" sim.log

// ==== tb/iss_model.svh ====
// Random source seeded once for the whole run
logic [15:0] lfsr_state = 16'd51176;
logic [31:0] prog[$];
logic [31:0] iss_reg [32] = '{default: '0};
logic [31:0] ref_mem [256];
logic [31:0] exp_addr[$];
logic [31:0] exp_data[$];

function automatic logic lfsr_bit();
	logic b;
	b = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (b)
		lfsr_state = lfsr_state ^ 16'hb400;
	return b;
endfunction

function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[30:0], lfsr_bit()};
	return v;
endfunction

function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
	return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
	return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic logic [31:0] s_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [11:0] imm);
	return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
	return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] u_type(input logic [6:0] op, input logic [4:0] rd,
		input logic [19:0] imm);
	return {imm, rd, op};
endfunction

function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
	return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

// A register write is followed by three fillers before any use
function automatic void add_write(input logic [31:0] instr);
	prog.push_back(instr);
	repeat (3) prog.push_back(NOP);
endfunction

function automatic logic [4:0] rreg();
	return 5'(32'd1 + rand_bits(3) % 32'd7);
endfunction

function automatic void build_program(input int segs);
	logic [4:0]  rd;
	logic [4:0]  rs1;
	logic [4:0]  rs2;
	logic [11:0] off;
	logic [1:0]  lane;
	logic [3:0]  rop;
	logic [2:0]  kind;
	logic [2:0]  ifn [5] = '{3'd0, 3'd7, 3'd6, 3'd4, 3'd2};
	logic [3:0]  rfn [7] = '{4'b0000, 4'b1000, 4'b0111, 4'b0110, 4'b0100, 4'b0010, 4'b0001};
	prog.delete();
	// x31 is the data base pointer
	add_write(i_type(OP_IMM, 3'd0, 5'd31, 5'd0, 12'h200));
	for (int r = 1; r < 8; r++)
		add_write(i_type(OP_IMM, 3'd0, 5'(r), 5'd0, 12'(rand_bits(12))));
	for (int s = 0; s < segs; s++) begin
		rd   = rreg();
		rs1  = rreg();
		rs2  = rreg();
		off  = 12'(rand_bits(6) << 2);
		lane = 2'(rand_bits(2));
		kind = 3'(rand_bits(3));
		case (kind)
			0, 1: add_write(i_type(OP_IMM, ifn[rand_bits(3) % 5], rd, rs1,
				12'(rand_bits(12))));
			2: begin
				rop = rfn[rand_bits(3) % 7];
				add_write(r_type({1'b0, rop[3], 5'b0}, rop[2:0], rd, rs1, rs2));
			end
			3: begin
				prog.push_back(s_type(3'd2, 5'd31, rs1, off));
				if (lfsr_bit()) begin
					prog.push_back(s_type(3'd0, 5'd31, rs2, off + 12'(lane)));
					add_write(i_type(OP_LOAD, 3'd2, rd, 5'd31, off));
				end else begin
					add_write(i_type(OP_LOAD, lfsr_bit() ? 3'd4 : 3'd0, rd, 5'd31,
						off + 12'(lane)));
				end
			end
			4: begin
				// Delay slot then a store that a taken branch skips
				prog.push_back(b_type(lfsr_bit() ? 3'd1 : 3'd0, rs1,
					lfsr_bit() ? rs1 : rs2, 13'd12));
				prog.push_back(s_type(3'd2, 5'd31, rs1, off));
				prog.push_back(s_type(3'd2, 5'd31, rs2, off ^ 12'h100));
			end
			5: begin
				prog.push_back(j_type(rd, 21'd12));
				prog.push_back(s_type(3'd2, 5'd31, 5'd31, off));
				prog.push_back(s_type(3'd2, 5'd31, 5'd31, off ^ 12'h100));
				repeat (3) prog.push_back(NOP);
			end
			6: add_write(u_type(OP_LUI, rd, 20'(rand_bits(20))));
			default: add_write(u_type(OP_AUIPC, rd, 20'(rand_bits(20))));
		endcase
		// Sometimes rd is read as the third instruction after its write
		if (kind != 3'd4 && kind != 3'd5 && lfsr_bit())
			prog.delete(prog.size() - 1);
		prog.push_back(s_type(3'd2, 5'd31, rd, 12'(rand_bits(6) << 2)));
	end
	// Sentinel store followed by a spin loop
	add_write(i_type(OP_IMM, 3'd0, 5'd30, 5'd0, 12'h5a5));
	prog.push_back(s_type(3'd2, 5'd0, 5'd30, 12'h0fc));
	prog.push_back(j_type(5'd0, 21'd0));
	prog.push_back(NOP);
endfunction

// Architectural model with one delay slot after every branch and jump
function automatic void run_iss();
	logic [31:0] pc, npc, nnpc, ins, a, val, d, w, x, y;
	logic [31:0] immi, imms, immb, immu, immj;
	logic [7:0]  byt;
	logic        wr;
	pc  = 32'd0;
	npc = 32'd4;
	for (int step = 0; step < 4096; step++) begin
		ins = prog[pc >> 2];
		if (ins == j_type(5'd0, 21'd0))
			break;
		x    = iss_reg[ins[19:15]];
		y    = iss_reg[ins[24:20]];
		immi = {{20{ins[31]}}, ins[31:20]};
		imms = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immb = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		immu = {ins[31:12], 12'b0};
		immj = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		nnpc = npc + 32'd4;
		wr   = 1'b0;
		val  = '0;
		case (ins[6:0])
			OP_LUI: begin
				val = immu;
				wr  = 1'b1;
			end
			OP_AUIPC: begin
				val = pc + immu;
				wr  = 1'b1;
			end
			OP_JAL: begin
				val  = pc + 32'd4;
				wr   = 1'b1;
				nnpc = pc + immj;
			end
			OP_BRANCH:
				if ((ins[12] == 1'b0) == (x == y))
					nnpc = pc + immb;
			OP_LOAD: begin
				a   = x + immi;
				w   = ref_mem[a[9:2]];
				byt = w[{a[1:0], 3'b000} +: 8];
				wr  = 1'b1;
				case (ins[14:12])
					3'd0:    val = {{24{byt[7]}}, byt};
					3'd4:    val = {24'b0, byt};
					default: val = w;
				endcase
			end
			OP_STORE: begin
				a = x + imms;
				if (ins[14:12] == 3'd2) begin
					d = y;
					ref_mem[a[9:2]] = y;
				end else begin
					d = {24'b0, y[7:0]} << {a[1:0], 3'b000};
					ref_mem[a[9:2]][{a[1:0], 3'b000} +: 8] = y[7:0];
				end
				exp_addr.push_back(a);
				exp_data.push_back(d);
			end
			OP_IMM: begin
				wr = 1'b1;
				case (ins[14:12])
					3'd0:    val = x + immi;
					3'd7:    val = x & immi;
					3'd6:    val = x | immi;
					3'd4:    val = x ^ immi;
					default: val = {31'b0, $signed(x) < $signed(immi)};
				endcase
			end
			OP_REG: begin
				wr = 1'b1;
				case ({ins[30], ins[14:12]})
					4'b1000: val = x - y;
					4'b0111: val = x & y;
					4'b0110: val = x | y;
					4'b0100: val = x ^ y;
					4'b0010: val = {31'b0, $signed(x) < $signed(y)};
					4'b0001: val = x << y[4:0];
					default: val = x + y;
				endcase
			end
			default: ;
		endcase
		if (wr && ins[11:7] != 5'd0)
			iss_reg[ins[11:7]] = val;
		pc  = npc;
		npc = nnpc;
	end
endfunction

// ==== tb/cpu_tb.sv ====
`timescale 1ns/1ns

module cpu_tb import rv_pkg::*; ();

	localparam int PROGRAMS = 8;
	localparam int SEGMENTS = 12;

	logic        clk;
	logic        arst_n;
	logic        debug;
	logic [31:0] data_cpu;
	logic [31:0] waddr_cpu;
	logic [31:0] waddr_out;
	logic [31:0] data_out;
	logic        store_en;
	int          errors = 0;
	int          checks = 0;
	int          stores = 0;
	int          prog_no = 0;
	int          budget = 0;

	`include "iss_model.svh"

	tb_clock i_tb_clock (
		.clk    (clk),
		.arst_n (arst_n)
	);

	cpu i_cpu (
		.clk       (clk),
		.arst_n    (arst_n),
		.debug     (debug),
		.data_cpu  (data_cpu),
		.waddr_cpu (waddr_cpu),
		.waddr_out (waddr_out),
		.data_out  (data_out),
		.store_en  (store_en)
	);

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Store trace check, sampled before the edge updates the pipeline
	always @(posedge clk) begin
		if (store_en) begin
			if (debug || !arst_n) begin
				errors++;
				$display("Store strobe seen during reset or boot");
			end else if (exp_addr.size() == 0) begin
				errors++;
				$display("Unexpected store to %h in program %0d", waddr_out, prog_no);
			end else begin
				compare($sformatf("program %0d store %0d addr", prog_no, stores),
					exp_addr.pop_front(), waddr_out);
				compare($sformatf("program %0d store %0d data", prog_no, stores),
					exp_data.pop_front(), data_out);
				stores++;
			end
		end
	end

	always @(posedge clk) begin
		if (budget > 0) begin
			budget--;
			if (budget == 0) begin
				$display("Watchdog expired: program %0d did not finish its stores", prog_no);
				$display("Simulation finished: FAIL");
				$finish;
			end
		end
	end

	initial begin
		int errs_before;
		debug     = 1'b1;
		data_cpu  = '0;
		waddr_cpu = '0;
		@(posedge arst_n);
		@(posedge clk);
		for (int p = 0; p < PROGRAMS; p++) begin
			prog_no     = p;
			stores      = 0;
			errs_before = errors;
			build_program(SEGMENTS);
			budget = 50 * prog.size() + prog.size() + 100;
			// Boot load into both memories
			for (int i = 0; i < prog.size(); i++) begin
				@(posedge clk);
				debug     <= 1'b1;
				waddr_cpu <= 32'(i * 4);
				data_cpu  <= prog[i];
				ref_mem[i] = prog[i];
			end
			run_iss();
			@(posedge clk);
			debug <= 1'b0;
			while (exp_addr.size() != 0)
				@(posedge clk);
			// Let the spin loop settle before the next boot
			repeat (6) @(posedge clk);
			budget = 0;
			$display("Program %0d: %0d stores, %0d errors", p, stores, errors - errs_before);
		end
		$display("Checks %0d, errors %0d, programs %0d", checks, errors, PROGRAMS);
		if (errors == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic arst_n
);

	initial clk = 1'b0;

	// 8 ns period
	always #4 clk = ~clk;

	initial begin
		arst_n = 1'b0;
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

// ==== hw/cpu.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu import rv_pkg::*; #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            debug,
	input  logic [XLEN-1:0] data_cpu,
	input  logic [XLEN-1:0] waddr_cpu,
	output logic [XLEN-1:0] waddr_out,
	output logic [XLEN-1:0] data_out,
	output logic            store_en
);

	if_id_t          if_id;
	id_ex_t          id_ex;
	ex_mem_t         ex_mem;
	mem_wb_t         mem_wb;
	logic            take_branch;
	logic [XLEN-1:0] branch_pc;

	fetch #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
		.clk         (clk),
		.arst_n      (arst_n),
		.debug       (debug),
		.data_cpu    (data_cpu),
		.waddr_cpu   (waddr_cpu),
		.take_branch (take_branch),
		.branch_pc   (branch_pc),
		.if_id       (if_id)
	);

	// Branch and JAL resolve here, one delay slot follows
	decode i_decode (
		.clk         (clk),
		.arst_n      (arst_n),
		.if_id       (if_id),
		.mem_wb      (mem_wb),
		.id_ex       (id_ex),
		.take_branch (take_branch),
		.branch_pc   (branch_pc)
	);

	execute i_execute (
		.clk    (clk),
		.arst_n (arst_n),
		.id_ex  (id_ex),
		.ex_mem (ex_mem)
	);

	memory #(.DMEM_WORDS(DMEM_WORDS)) i_memory (
		.clk       (clk),
		.arst_n    (arst_n),
		.debug     (debug),
		.data_cpu  (data_cpu),
		.waddr_cpu (waddr_cpu),
		.ex_mem    (ex_mem),
		.mem_wb    (mem_wb),
		.waddr_out (waddr_out),
		.data_out  (data_out),
		.store_en  (store_en)
	);

endmodule

`default_nettype wire

// ==== hw/memory.sv ====
`timescale 1ns/1ns
`default_nettype none

module memory import rv_pkg::*; #(
	parameter int DMEM_WORDS = 256
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            debug,
	input  logic [XLEN-1:0] data_cpu,
	input  logic [XLEN-1:0] waddr_cpu,
	input  ex_mem_t         ex_mem,
	output mem_wb_t         mem_wb,
	output logic [XLEN-1:0] waddr_out,
	output logic [XLEN-1:0] data_out,
	output logic            store_en
);

	localparam int AW = $clog2(DMEM_WORDS);

	logic [1:0]      lane;
	logic [XLEN-1:0] st_data;
	logic [3:0]      st_be;
	logic [XLEN-1:0] alu_q;
	logic [4:0]      rd_q;
	mem_size_e       size_q;
	logic [1:0]      lane_q;
	logic            reg_write_q;
	logic            mem_read_q;
	logic [7:0]      ld_byte;

	mem_if #(.WORDS(DMEM_WORDS)) dmem ();

	word_ram #(.WORDS(DMEM_WORDS)) i_dmem (
		.clk  (clk),
		.port (dmem.ram)
	);

	assign lane = ex_mem.result[1:0];

	// SB lands on its own lane with one byte enable
	always_comb begin
		if (ex_mem.mem_size == WORD) begin
			st_data = ex_mem.store_data;
			st_be   = 4'hf;
		end else begin
			st_data = {24'b0, ex_mem.store_data[7:0]} << {lane, 3'b000};
			st_be   = 4'b0001 << lane;
		end
	end

	// Boot writes take the port over
	assign dmem.addr  = debug ? waddr_cpu[AW+1:2] : ex_mem.result[AW+1:2];
	assign dmem.wdata = debug ? data_cpu : st_data;
	assign dmem.be    = debug ? 4'hf : st_be;
	assign dmem.we    = debug | ex_mem.mem_write;

	assign waddr_out = ex_mem.result;
	assign data_out  = st_data;
	assign store_en  = ex_mem.mem_write & ~debug;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			reg_write_q <= 1'b0;
			mem_read_q  <= 1'b0;
		end else begin
			reg_write_q <= ex_mem.reg_write;
			mem_read_q  <= ex_mem.mem_read;
		end
	end

	always_ff @(posedge clk) begin
		alu_q  <= ex_mem.result;
		rd_q   <= ex_mem.rd;
		size_q <= ex_mem.mem_size;
		lane_q <= lane;
	end

	// Load extraction from the ram output word
	assign ld_byte = dmem.rdata[{lane_q, 3'b000} +: 8];

	always_comb begin
		mem_wb.alu_result = alu_q;
		mem_wb.mem_read   = mem_read_q;
		mem_wb.rd         = rd_q;
		mem_wb.reg_write  = reg_write_q;
		case (size_q)
			BYTE_S:  mem_wb.load_data = {{24{ld_byte[7]}}, ld_byte};
			BYTE_U:  mem_wb.load_data = {24'b0, ld_byte};
			default: mem_wb.load_data = dmem.rdata;
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module execute import rv_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  id_ex_t  id_ex,
	output ex_mem_t ex_mem
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_out;
	logic [XLEN-1:0] result;

	// pc as operand A for AUIPC
	assign op_a = id_ex.pc_as_a ? id_ex.pc : id_ex.rs1_data;
	assign op_b = id_ex.use_imm ? id_ex.imm : id_ex.rs2_data;

	always_comb begin
		case (id_ex.alu_op)
			ALU_ADD:    alu_out = op_a + op_b;
			ALU_SUB:    alu_out = op_a - op_b;
			ALU_AND:    alu_out = op_a & op_b;
			ALU_OR:     alu_out = op_a | op_b;
			ALU_XOR:    alu_out = op_a ^ op_b;
			ALU_SLT:    alu_out = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
			ALU_SLL:    alu_out = op_a << op_b[4:0];
			ALU_PASS_B: alu_out = op_b;
			default:    alu_out = '0;
		endcase
	end

	// JAL link value
	assign result = id_ex.link ? id_ex.pc + 32'd4 : alu_out;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_mem.reg_write <= 1'b0;
			ex_mem.mem_read  <= 1'b0;
			ex_mem.mem_write <= 1'b0;
		end else begin
			ex_mem.result     <= result;
			ex_mem.store_data <= id_ex.rs2_data;
			ex_mem.mem_read   <= id_ex.mem_read;
			ex_mem.mem_write  <= id_ex.mem_write;
			ex_mem.mem_size   <= id_ex.mem_size;
			ex_mem.rd         <= id_ex.rd;
			ex_mem.reg_write  <= id_ex.reg_write;
		end
	end

endmodule

`default_nettype wire

// ==== hw/decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode import rv_pkg::*; (
	input  logic            clk,
	input  logic            arst_n,
	input  if_id_t          if_id,
	input  mem_wb_t         mem_wb,
	output id_ex_t          id_ex,
	output logic            take_branch,
	output logic [XLEN-1:0] branch_pc
);

	logic [XLEN-1:0] instr;
	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
	logic [XLEN-1:0] rs1_data, rs2_data;
	logic [XLEN-1:0] wb_data;
	logic            legal;
	logic            jump;
	id_ex_t          next;

	assign instr  = if_id.instr;
	assign opcode = opcode_e'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	// Writeback select
	assign wb_data = mem_wb.mem_read ? mem_wb.load_data : mem_wb.alu_result;

	reg_file i_reg_file (
		.clk      (clk),
		.arst_n   (arst_n),
		.rs1      (instr[19:15]),
		.rs2      (instr[24:20]),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.we       (mem_wb.reg_write),
		.rd       (mem_wb.rd),
		.wdata    (wb_data)
	);

	always_comb begin
		next          = '0;
		next.pc       = if_id.pc;
		next.rs1_data = rs1_data;
		next.rs2_data = rs2_data;
		next.rd       = instr[11:7];
		next.alu_op   = ALU_ADD;
		next.mem_size = WORD;
		legal         = 1'b1;
		jump          = 1'b0;
		take_branch   = 1'b0;
		case (opcode)
			OP_LUI: begin
				next.imm       = imm_u;
				next.use_imm   = 1'b1;
				next.alu_op    = ALU_PASS_B;
				next.reg_write = 1'b1;
			end
			OP_AUIPC: begin
				next.imm       = imm_u;
				next.use_imm   = 1'b1;
				next.pc_as_a   = 1'b1;
				next.reg_write = 1'b1;
			end
			OP_JAL: begin
				next.link      = 1'b1;
				next.reg_write = 1'b1;
				jump           = 1'b1;
				take_branch    = 1'b1;
			end
			OP_BRANCH: begin
				// BEQ and BNE only
				case (funct3)
					3'b000:  take_branch = (rs1_data == rs2_data);
					3'b001:  take_branch = (rs1_data != rs2_data);
					default: legal = 1'b0;
				endcase
			end
			OP_LOAD: begin
				next.imm       = imm_i;
				next.use_imm   = 1'b1;
				next.mem_read  = 1'b1;
				next.reg_write = 1'b1;
				case (funct3)
					3'b000:  next.mem_size = BYTE_S;
					3'b010:  next.mem_size = WORD;
					3'b100:  next.mem_size = BYTE_U;
					default: legal = 1'b0;
				endcase
			end
			OP_STORE: begin
				next.imm       = imm_s;
				next.use_imm   = 1'b1;
				next.mem_write = 1'b1;
				case (funct3)
					3'b000:  next.mem_size = BYTE_S;
					3'b010:  next.mem_size = WORD;
					default: legal = 1'b0;
				endcase
			end
			OP_IMM: begin
				next.imm       = imm_i;
				next.use_imm   = 1'b1;
				next.reg_write = 1'b1;
				case (funct3)
					3'b000:  next.alu_op = ALU_ADD;
					3'b111:  next.alu_op = ALU_AND;
					3'b110:  next.alu_op = ALU_OR;
					3'b100:  next.alu_op = ALU_XOR;
					3'b010:  next.alu_op = ALU_SLT;
					default: legal = 1'b0;
				endcase
			end
			OP_REG: begin
				next.reg_write = 1'b1;
				case ({funct7, funct3})
					{7'b0000000, 3'b000}: next.alu_op = ALU_ADD;
					{7'b0100000, 3'b000}: next.alu_op = ALU_SUB;
					{7'b0000000, 3'b111}: next.alu_op = ALU_AND;
					{7'b0000000, 3'b110}: next.alu_op = ALU_OR;
					{7'b0000000, 3'b100}: next.alu_op = ALU_XOR;
					{7'b0000000, 3'b010}: next.alu_op = ALU_SLT;
					{7'b0000000, 3'b001}: next.alu_op = ALU_SLL;
					default:              legal = 1'b0;
				endcase
			end
			default: legal = 1'b0;
		endcase

		// Unsupported encodings become bubbles
		if (!legal) begin
			next.reg_write = 1'b0;
			next.mem_read  = 1'b0;
			next.mem_write = 1'b0;
			take_branch    = 1'b0;
		end
		// Writes to x0 are dropped here so NOPs carry no write
		if (next.rd == 5'd0)
			next.reg_write = 1'b0;
	end

	assign branch_pc = if_id.pc + (jump ? imm_j : imm_b);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			id_ex.reg_write <= 1'b0;
			id_ex.mem_read  <= 1'b0;
			id_ex.mem_write <= 1'b0;
		end else begin
			id_ex <= next;
		end
	end

endmodule

`default_nettype wire

// ==== hw/reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file import rv_pkg::*; (
	input  logic            clk,
	input  logic            arst_n,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	output logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] rs2_data,
	input  logic            we,
	input  logic [4:0]      rd,
	input  logic [XLEN-1:0] wdata
);

	// x0 has no storage
	logic [XLEN-1:0] regs [1:31];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin
			regs[rd] <= wdata;
		end
	end

	function automatic logic [XLEN-1:0] read_reg(input logic [4:0] sel);
		if (sel == 5'd0)
			return '0;
		// Write in flight goes straight to the reader
		if (we && sel == rd)
			return wdata;
		return regs[sel];
	endfunction

	always_comb begin
		rs1_data = read_reg(rs1);
		rs2_data = read_reg(rs2);
	end

endmodule

`default_nettype wire

// ==== hw/fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetch import rv_pkg::*; #(
	parameter int IMEM_WORDS = 256
) (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            debug,
	input  logic [XLEN-1:0] data_cpu,
	input  logic [XLEN-1:0] waddr_cpu,
	input  logic            take_branch,
	input  logic [XLEN-1:0] branch_pc,
	output if_id_t          if_id
);

	localparam int AW = $clog2(IMEM_WORDS);

	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] pc_q;
	logic            valid_q;

	mem_if #(.WORDS(IMEM_WORDS)) imem ();

	word_ram #(.WORDS(IMEM_WORDS)) i_imem (
		.clk  (clk),
		.port (imem.ram)
	);

	// Boot loader owns the port while debug is high
	assign imem.addr  = debug ? waddr_cpu[AW+1:2] : pc[AW+1:2];
	assign imem.wdata = data_cpu;
	assign imem.be    = 4'hf;
	assign imem.we    = debug;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pc      <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= ~debug;
			if (debug)
				pc <= '0;
			else if (take_branch)
				pc <= branch_pc;
			else
				pc <= pc + 32'd4;
		end
	end

	// Track the pc of the word now in the ram output register
	always_ff @(posedge clk) begin
		pc_q <= pc;
	end

	assign if_id.pc    = pc_q;
	assign if_id.instr = valid_q ? imem.rdata : NOP;

endmodule

`default_nettype wire

// ==== hw/word_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module word_ram import rv_pkg::*; #(
	parameter int WORDS = 256
) (
	input logic clk,
	mem_if.ram  port
);

	logic [XLEN-1:0] mem [WORDS];

	// Per-byte write enables
	always_ff @(posedge clk) begin
		if (port.we) begin
			for (int i = 0; i < 4; i++) begin
				if (port.be[i]) begin
					mem[port.addr][8*i +: 8] <= port.wdata[8*i +: 8];
				end
			end
		end
	end

	// Synchronous read, old data on a same-cycle write
	always_ff @(posedge clk) begin
		port.rdata <= mem[port.addr];
	end

endmodule

`default_nettype wire

// ==== hw/mem_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface mem_if import rv_pkg::*; #(
	parameter int WORDS = 256
) ();

	// Word index, not byte address
	logic [$clog2(WORDS)-1:0] addr;
	logic [XLEN-1:0]          wdata;
	logic [3:0]               be;
	logic                     we;
	logic [XLEN-1:0]          rdata;

	modport stage (output addr, wdata, be, we, input rdata);
	modport ram (input addr, wdata, be, we, output rdata);

endinterface

`default_nettype wire

// ==== hw/rv_pkg.sv ====
package rv_pkg;

	localparam int XLEN = 32;

	// ADDI x0, x0, 0
	localparam logic [XLEN-1:0] NOP = 32'h0000_0013;

	typedef enum logic [6:0] {
		OP_LUI    = 7'b0110111,
		OP_AUIPC  = 7'b0010111,
		OP_JAL    = 7'b1101111,
		OP_BRANCH = 7'b1100011,
		OP_LOAD   = 7'b0000011,
		OP_STORE  = 7'b0100011,
		OP_IMM    = 7'b0010011,
		OP_REG    = 7'b0110011
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		BYTE_S,
		BYTE_U,
		WORD
	} mem_size_e;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] instr;
	} if_id_t;

	typedef struct packed {
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rs1_data;
		logic [XLEN-1:0] rs2_data;
		logic [XLEN-1:0] imm;
		logic            use_imm;
		logic            pc_as_a;
		logic            link;
		alu_op_e         alu_op;
		logic            mem_read;
		logic            mem_write;
		mem_size_e       mem_size;
		logic [4:0]      rd;
		logic            reg_write;
	} id_ex_t;

	typedef struct packed {
		logic [XLEN-1:0] result;
		logic [XLEN-1:0] store_data;
		logic            mem_read;
		logic            mem_write;
		mem_size_e       mem_size;
		logic [4:0]      rd;
		logic            reg_write;
	} ex_mem_t;

	typedef struct packed {
		logic [XLEN-1:0] alu_result;
		logic [XLEN-1:0] load_data;
		logic            mem_read;
		logic [4:0]      rd;
		logic            reg_write;
	} mem_wb_t;

endpackage
